//--- common/core_consts.svh
// Core constants
// Widths, register count and credit depths shared by the pipeline stages

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_INSTR_W        16  // Instruction word
`define CORE_DATA_W         16  // Datapath width
`define CORE_REG_CNT        8   // Register 0 reads zero
`define CORE_REG_AW         3   // Register index width
`define CORE_IMM_W          6   // Signed immediate field

// Flow control
`define CORE_INSTR_CREDITS  2   // Input buffer depth
`define CORE_RETIRE_CREDITS 4   // Consumer credits after reset

// Trace fields
`define CORE_SEQ_W          16
`define CORE_LAT_W          8

`endif

//--- common/core_pkg.sv
// Core package
// Opcode encoding and the two instruction word formats

`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SHL  = 4'd5,
        OP_ADDI = 4'd6,
        OP_XORI = 4'd7  // Remaining codes write zero
    } opcode_e;

    ////////////////////
    // Register format
    ////////////////////
    typedef struct packed {
        opcode_e                opcode;  // [15:12]
        logic [`CORE_REG_AW-1:0] rd;     // [11:9]
        logic [`CORE_REG_AW-1:0] rs1;    // [8:6]
        logic [`CORE_REG_AW-1:0] rs2;    // [5:3]
        logic [2:0]             unused;
    } rfmt_t;

    ////////////////////
    // Immediate format
    ////////////////////
    typedef struct packed {
        opcode_e                      opcode;
        logic [`CORE_REG_AW-1:0]       rd;
        logic [`CORE_REG_AW-1:0]       rs1;
        logic signed [`CORE_IMM_W-1:0] imm;  // Sign-extended in decode
    } ifmt_t;

    // One word, two views
    typedef union packed {
        rfmt_t r;
        ifmt_t i;
    } instr_t;

endpackage

`default_nettype wire

//--- decode/instr_decode.sv
// Instruction decode
// Credit-managed input buffer, instruction decode and the register file

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module instr_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  logic [`CORE_INSTR_W-1:0]       instr,
    input  logic                           advance,
    input  logic                           wb_en,
    input  logic [`CORE_REG_AW-1:0]        wb_rd,
    input  logic [`CORE_DATA_W-1:0]        wb_value,
    output logic                           instr_credit,
    output logic                           dec_valid,
    output core_pkg::opcode_e              dec_op,
    output logic [`CORE_REG_AW-1:0]        dec_rd,
    output logic [`CORE_REG_AW-1:0]        dec_rs1,
    output logic [`CORE_REG_AW-1:0]        dec_rs2,
    output logic                           dec_use_imm,
    output logic [`CORE_DATA_W-1:0]        dec_imm,
    output logic [`CORE_DATA_W-1:0]        dec_a,
    output logic [`CORE_DATA_W-1:0]        dec_b
);

    localparam int BUF_AW = $clog2(`CORE_INSTR_CREDITS);
    localparam int CNT_W  = $clog2(`CORE_INSTR_CREDITS + 1);

    core_pkg::instr_t        buf_mem [`CORE_INSTR_CREDITS];
    logic [BUF_AW-1:0]       wr_ptr;
    logic [BUF_AW-1:0]       rd_ptr;
    logic [CNT_W-1:0]        buf_cnt;
    logic                    pop;
    logic [`CORE_DATA_W-1:0] regs [`CORE_REG_CNT];

    core_pkg::instr_t        head;
    core_pkg::opcode_e       head_op;
    logic                    head_imm;

    ////////////////////
    // Input buffer
    ////////////////////
    assign pop = advance && (buf_cnt != '0);  // Pushed entries wait one edge

    always_ff @(posedge clk) begin
        if (instr_valid)
            buf_mem[wr_ptr] <= instr;  // Producer only sends against a credit
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            buf_cnt      <= '0;
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            buf_cnt      <= buf_cnt + CNT_W'(instr_valid) - CNT_W'(pop);
            instr_credit <= pop;  // One credit back per freed entry
        end
    end

    // Register read with same-cycle write passed through
    function automatic logic [`CORE_DATA_W-1:0] rf_read(input logic [`CORE_REG_AW-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb_en && (wb_rd == idx))
            return wb_value;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_en)
            regs[wb_rd] <= wb_value;  // Never rd 0
    end

    ////////////////////
    // Decode
    ////////////////////
    assign head     = buf_mem[rd_ptr];
    assign head_op  = head.r.opcode;
    assign head_imm = (head_op == core_pkg::OP_ADDI) || (head_op == core_pkg::OP_XORI);

    always_ff @(posedge clk) begin
        if (rst)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= pop;  // Bubble when the buffer is empty
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dec_op      <= head_op;
            dec_rd      <= head.r.rd;
            dec_rs1     <= head.r.rs1;
            dec_use_imm <= head_imm;
            dec_a       <= rf_read(head.r.rs1);
            dec_b       <= rf_read(head.r.rs2);
            if (head_imm) begin
                dec_rs2 <= '0;  // No second source register
                dec_imm <= {{(`CORE_DATA_W - `CORE_IMM_W){head.i.imm[`CORE_IMM_W-1]}},
                            head.i.imm};
            end else begin
                dec_rs2 <= head.r.rs2;
                dec_imm <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- execute/alu_execute.sv
// Execute stage
// Operand forwarding, 16-bit ALU and the execute pipeline register

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module alu_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  logic                    dec_valid,
    input  core_pkg::opcode_e       dec_op,
    input  logic [`CORE_REG_AW-1:0] dec_rd,
    input  logic [`CORE_REG_AW-1:0] dec_rs1,
    input  logic [`CORE_REG_AW-1:0] dec_rs2,
    input  logic                    dec_use_imm,
    input  logic [`CORE_DATA_W-1:0] dec_imm,
    input  logic [`CORE_DATA_W-1:0] dec_a,
    input  logic [`CORE_DATA_W-1:0] dec_b,
    input  logic                    wb_en,
    input  logic [`CORE_REG_AW-1:0] wb_rd,
    input  logic [`CORE_DATA_W-1:0] wb_value,
    output logic                    ex_valid,
    output logic [`CORE_REG_AW-1:0] ex_rd,
    output logic [`CORE_DATA_W-1:0] ex_value
);

    logic [`CORE_DATA_W-1:0] op_a;
    logic [`CORE_DATA_W-1:0] op_b;
    logic [`CORE_DATA_W-1:0] result;

    // Newest producer wins, register 0 never forwarded
    function automatic logic [`CORE_DATA_W-1:0] fwd(input logic [`CORE_REG_AW-1:0] rs,
                                                    input logic [`CORE_DATA_W-1:0] dval);
        if (rs == '0)
            return dval;
        if (ex_valid && (ex_rd == rs))
            return ex_value;  // Previous instruction
        if (wb_en && (wb_rd == rs))
            return wb_value;  // Retire register
        return dval;
    endfunction

    assign op_a = fwd(dec_rs1, dec_a);
    assign op_b = dec_use_imm ? dec_imm : fwd(dec_rs2, dec_b);

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (dec_op)
            core_pkg::OP_ADD,
            core_pkg::OP_ADDI: result = op_a + op_b;
            core_pkg::OP_SUB:  result = op_a - op_b;
            core_pkg::OP_AND:  result = op_a & op_b;
            core_pkg::OP_OR:   result = op_a | op_b;
            core_pkg::OP_XOR,
            core_pkg::OP_XORI: result = op_a ^ op_b;
            core_pkg::OP_SHL:  result = op_a << op_b[3:0];
            default:           result = '0;  // Undefined opcodes
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            ex_valid <= 1'b0;
        else if (advance)
            ex_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rd    <= dec_rd;
            ex_value <= result;
        end
    end

endmodule

`default_nettype wire

//--- src/retire_result.sv
// Retire stage
// Writeback register, retire credit counter and the pipeline advance decision

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module retire_result (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid,
    input  logic [`CORE_REG_AW-1:0] ex_rd,
    input  logic [`CORE_DATA_W-1:0] ex_value,
    input  logic                    retire_credit,
    output logic                    advance,
    output logic                    wb_en,
    output logic [`CORE_REG_AW-1:0] wb_rd,
    output logic [`CORE_DATA_W-1:0] wb_value,
    output logic                    retire_valid,
    output logic [`CORE_REG_AW-1:0] retire_rd,
    output logic [`CORE_DATA_W-1:0] retire_value
);

    localparam int CW = $clog2(`CORE_RETIRE_CREDITS + 1);

    logic                    ret_valid;
    logic [`CORE_REG_AW-1:0] ret_rd;
    logic [`CORE_DATA_W-1:0] ret_value;
    logic [CW-1:0]           credit_cnt;
    logic                    has_credit;

    assign has_credit = (credit_cnt != '0);

    // Stall only when a held record cannot leave
    assign advance      = !ret_valid || has_credit;
    assign retire_valid = ret_valid && has_credit;
    assign retire_rd    = ret_rd;
    assign retire_value = ret_value;

    // Register file write on acceptance
    assign wb_en    = retire_valid && (ret_rd != '0);
    assign wb_rd    = ret_rd;
    assign wb_value = ret_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            ret_valid  <= 1'b0;
            credit_cnt <= CW'(`CORE_RETIRE_CREDITS);
        end else begin
            if (advance)
                ret_valid <= ex_valid;
            credit_cnt <= credit_cnt + CW'(retire_credit) - CW'(retire_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ret_rd    <= ex_rd;
            ret_value <= ex_value;
        end
    end

endmodule

`default_nettype wire

//--- src/pipe_trace.sv
// Pipeline trace
// Numbers issued instructions and counts their cycles from issue to retire

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module pipe_trace (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  logic                   dec_valid,
    input  logic                   ex_valid,
    output logic [`CORE_SEQ_W-1:0] retire_seq,
    output logic [`CORE_LAT_W-1:0] retire_latency
);

    logic [`CORE_SEQ_W-1:0] seq_cnt;  // Number of the decode occupant
    logic [`CORE_SEQ_W-1:0] ex_seq;
    logic [`CORE_SEQ_W-1:0] ret_seq;
    logic [`CORE_LAT_W-1:0] dec_lat;
    logic [`CORE_LAT_W-1:0] ex_lat;
    logic [`CORE_LAT_W-1:0] ret_lat;

    // Holds at the top instead of wrapping on long stalls
    function automatic logic [`CORE_LAT_W-1:0] sat_inc(input logic [`CORE_LAT_W-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst)
            seq_cnt <= '0;
        else if (advance && dec_valid)
            seq_cnt <= seq_cnt + 1'b1;
    end

    ////////////////////
    // Stage shadows
    ////////////////////
    always_ff @(posedge clk) begin
        if (advance) begin
            dec_lat <= '0;  // Issue edge
            if (dec_valid) begin
                ex_seq <= seq_cnt;
                ex_lat <= sat_inc(dec_lat);
            end
            if (ex_valid) begin
                ret_seq <= ex_seq;
                ret_lat <= sat_inc(ex_lat);
            end
        end else begin
            // Stalled edges still count
            dec_lat <= sat_inc(dec_lat);
            ex_lat  <= sat_inc(ex_lat);
            ret_lat <= sat_inc(ret_lat);
        end
    end

    assign retire_seq     = ret_seq;
    assign retire_latency = ret_lat;

endmodule

`default_nettype wire

//--- src/core_top.sv
// Core top level
// Decode, execute and retire stages with the trace unit alongside

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [`CORE_INSTR_W-1:0] instr,
    input  logic                    retire_credit,
    output logic                    instr_credit,
    output logic                    retire_valid,
    output logic [`CORE_REG_AW-1:0] retire_rd,
    output logic [`CORE_DATA_W-1:0] retire_value,
    output logic [`CORE_SEQ_W-1:0]  retire_seq,
    output logic [`CORE_LAT_W-1:0]  retire_latency
);

    logic                    advance;

    // Decode stage
    logic                    dec_valid;
    core_pkg::opcode_e       dec_op;
    logic [`CORE_REG_AW-1:0] dec_rd;
    logic [`CORE_REG_AW-1:0] dec_rs1;
    logic [`CORE_REG_AW-1:0] dec_rs2;
    logic                    dec_use_imm;
    logic [`CORE_DATA_W-1:0] dec_imm;
    logic [`CORE_DATA_W-1:0] dec_a;
    logic [`CORE_DATA_W-1:0] dec_b;

    // Execute stage
    logic                    ex_valid;
    logic [`CORE_REG_AW-1:0] ex_rd;
    logic [`CORE_DATA_W-1:0] ex_value;

    // Writeback
    logic                    wb_en;
    logic [`CORE_REG_AW-1:0] wb_rd;
    logic [`CORE_DATA_W-1:0] wb_value;

    instr_decode i_instr_decode (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .advance      (advance),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_value     (wb_value),
        .instr_credit (instr_credit),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .dec_rd       (dec_rd),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_use_imm  (dec_use_imm),
        .dec_imm      (dec_imm),
        .dec_a        (dec_a),
        .dec_b        (dec_b)
    );

    alu_execute i_alu_execute (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_use_imm (dec_use_imm),
        .dec_imm     (dec_imm),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_value    (ex_value)
    );

    retire_result i_retire_result (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_value      (ex_value),
        .retire_credit (retire_credit),
        .advance       (advance),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_value      (wb_value),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value)
    );

    pipe_trace i_pipe_trace (
        .clk            (clk),
        .rst            (rst),
        .advance        (advance),
        .dec_valid      (dec_valid),
        .ex_valid       (ex_valid),
        .retire_seq     (retire_seq),
        .retire_latency (retire_latency)
    );

endmodule

`default_nettype wire

//--- tb/core_assert.sv
// Core assertions
// Credit limits and reset behavior, bound to the retire and decode stages

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module core_assert #(
    parameter int CNT_W   = 3,
    parameter int MAX_CNT = 4,
    parameter bit GATED   = 1'b0  // Each pulse spends a far-side credit
) (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             out_pulse,
    input wire logic [CNT_W-1:0] out_cnt,
    input wire logic             credit_back  // Credit returned by the far side
);

    // Quiet output right after reset
    a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_pulse)
        else $error("output active in the cycle after reset");

    a_cnt_limit: assert property (@(posedge clk) disable iff (rst)
        out_cnt <= CNT_W'(MAX_CNT))
        else $error("count above its limit");

    generate
        if (GATED) begin : g_gated
            logic [CNT_W-1:0] in_flight;  // Pulses not yet credited back

            always_ff @(posedge clk) begin
                if (rst)
                    in_flight <= '0;
                else
                    in_flight <= in_flight + CNT_W'(out_pulse) - CNT_W'(credit_back);
            end

            a_pulse_needs_cnt: assert property (@(posedge clk) disable iff (rst)
                out_pulse |-> (in_flight < CNT_W'(MAX_CNT)))
                else $error("valid with no credit left");
        end
    endgenerate

endmodule

// Retire side: retire_valid against the credit counter
bind retire_result core_assert #(
    .CNT_W   (CW),
    .MAX_CNT (`CORE_RETIRE_CREDITS),
    .GATED   (1'b1)
) i_retire_assert (
    .clk         (clk),
    .rst         (rst),
    .out_pulse   (retire_valid),
    .out_cnt     (credit_cnt),
    .credit_back (retire_credit)
);

// Input side: buffer occupancy
bind instr_decode core_assert #(
    .CNT_W   (CNT_W),
    .MAX_CNT (`CORE_INSTR_CREDITS),
    .GATED   (1'b0)
) i_decode_assert (
    .clk         (clk),
    .rst         (rst),
    .out_pulse   (instr_credit),
    .out_cnt     (buf_cnt),
    .credit_back (1'b0)
);

`default_nettype wire

//--- tb/core_tb.sv
// Core testbench
// Credit-based producer and consumer around the core, checked against a model

`timescale 1ns/10ps
`default_nettype none

`include "core_consts.svh"

module core_tb;

    logic                    clk;
    logic                    rst;
    logic                    instr_valid;
    logic [`CORE_INSTR_W-1:0] instr;
    logic                    retire_credit;
    logic                    instr_credit;
    logic                    retire_valid;
    logic [`CORE_REG_AW-1:0] retire_rd;
    logic [`CORE_DATA_W-1:0] retire_value;
    logic [`CORE_SEQ_W-1:0]  retire_seq;
    logic [`CORE_LAT_W-1:0]  retire_latency;

    logic [`CORE_DATA_W-1:0] model_regs [`CORE_REG_CNT];
    core_pkg::instr_t        tx_q[$];
    core_pkg::instr_t        exp_ins_q[$];
    logic [`CORE_REG_AW-1:0] exp_rd_q[$];
    logic [`CORE_DATA_W-1:0] exp_val_q[$];

    int prod_credits;
    int owed;            // Credits held back from the core
    int credit_mode;     // 0 random, 1 immediate, 2 withheld
    bit lat_exact;
    int accepted_cnt;
    int retired_cnt;
    int pulse_cnt;
    int errors;
    int timeouts;
    logic [`CORE_SEQ_W-1:0] exp_seq;

    core_top i_core_top (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_credit  (retire_credit),
        .instr_credit   (instr_credit),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value),
        .retire_seq     (retire_seq),
        .retire_latency (retire_latency)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////
    function automatic void ref_exec(input core_pkg::instr_t ins,
                                     output logic [`CORE_REG_AW-1:0] rd,
                                     output logic [`CORE_DATA_W-1:0] value);
        logic [`CORE_DATA_W-1:0] a;
        logic [`CORE_DATA_W-1:0] b;
        logic [`CORE_DATA_W-1:0] imm;
        a   = (ins.r.rs1 == 0) ? '0 : model_regs[ins.r.rs1];
        b   = (ins.r.rs2 == 0) ? '0 : model_regs[ins.r.rs2];
        imm = `CORE_DATA_W'(signed'(ins.i.imm));
        case (ins.r.opcode)
            core_pkg::OP_ADD:  value = a + b;
            core_pkg::OP_SUB:  value = a - b;
            core_pkg::OP_AND:  value = a & b;
            core_pkg::OP_OR:   value = a | b;
            core_pkg::OP_XOR:  value = a ^ b;
            core_pkg::OP_SHL:  value = a << b[3:0];
            core_pkg::OP_ADDI: value = a + imm;
            core_pkg::OP_XORI: value = a ^ imm;
            default:           value = '0;
        endcase
        rd = ins.r.rd;
        if (rd != 0)
            model_regs[rd] = value;
    endfunction

    function automatic core_pkg::instr_t enc_r(input logic [3:0] op, input logic [2:0] rd,
                                               input logic [2:0] rs1, input logic [2:0] rs2);
        core_pkg::instr_t w;
        w.r = '{core_pkg::opcode_e'(op), rd, rs1, rs2, 3'b000};
        return w;
    endfunction

    function automatic core_pkg::instr_t enc_i(input logic [3:0] op, input logic [2:0] rd,
                                               input logic [2:0] rs1, input logic [5:0] imm);
        core_pkg::instr_t w;
        w.i = '{core_pkg::opcode_e'(op), rd, rs1, imm};
        return w;
    endfunction

    function automatic core_pkg::instr_t random_instr();
        logic [3:0]  op;
        logic [11:0] rest;
        op   = 4'($urandom % 10);  // Two undefined codes too
        rest = 12'($urandom);
        return core_pkg::instr_t'({op, rest});
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_result(input core_pkg::instr_t ins,
                                input logic [`CORE_REG_AW-1:0] rd,
                                input logic [`CORE_DATA_W-1:0] value,
                                input logic [`CORE_REG_AW-1:0] exp_rd,
                                input logic [`CORE_DATA_W-1:0] exp_value);
        if (rd !== exp_rd || value !== exp_value) begin
            errors++;
            $display("FAILED @%0t: instr %h gave rd %0d value %h, expected rd %0d value %h",
                     $time, ins, rd, value, exp_rd, exp_value);
        end
    endtask

    task automatic check_trace(input logic [`CORE_SEQ_W-1:0] seq,
                               input logic [`CORE_LAT_W-1:0] lat,
                               input logic [`CORE_SEQ_W-1:0] seq_exp,
                               input bit exact);
        if (seq !== seq_exp) begin
            errors++;
            $display("FAILED @%0t: seq %0d, expected %0d", $time, seq, seq_exp);
        end
        if (exact ? (lat !== 2) : (lat < 2)) begin
            errors++;
            $display("FAILED @%0t: latency %0d for seq %0d", $time, lat, seq);
        end
    endtask

    // Producer: spends one credit per instruction
    always @(posedge clk) begin
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_DATA_W-1:0] value;
        core_pkg::instr_t        w;
        if (rst) begin
            prod_credits = `CORE_INSTR_CREDITS;
            instr_valid <= 1'b0;
        end else begin
            if (instr_credit) begin
                prod_credits++;
                pulse_cnt++;
            end
            if (prod_credits > `CORE_INSTR_CREDITS) begin
                errors++;
                $display("Producer received more input credits than it spent");
            end
            if (prod_credits > 0 && tx_q.size() > 0) begin
                w = tx_q.pop_front();
                prod_credits--;
                instr_valid <= 1'b1;
                instr       <= w;
                ref_exec(w, rd, value);  // Acceptance order is issue order
                exp_ins_q.push_back(w);
                exp_rd_q.push_back(rd);
                exp_val_q.push_back(value);
                accepted_cnt++;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    end

    // Consumer and compare
    always @(posedge clk) begin
        if (rst) begin
            retire_credit <= 1'b0;
        end else begin
            if (retire_valid) begin
                if (exp_rd_q.size() == 0) begin
                    errors++;
                    $display("Retire seen with no instruction outstanding");
                end else begin
                    check_result(exp_ins_q.pop_front(), retire_rd, retire_value,
                                 exp_rd_q.pop_front(), exp_val_q.pop_front());
                end
                check_trace(retire_seq, retire_latency, exp_seq, lat_exact);
                exp_seq++;
                retired_cnt++;
                owed++;
            end
            if (owed > 0 && (credit_mode == 1 || (credit_mode == 0 && $urandom % 3 == 0))) begin
                retire_credit <= 1'b1;
                owed--;
            end else begin
                retire_credit <= 1'b0;
            end
        end
    end

    task automatic wait_drained(input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(posedge clk);
            n++;
            ok = (tx_q.size() == 0) && (exp_rd_q.size() == 0) && (owed == 0);
        end
        repeat (3) @(posedge clk);
        if (!ok) begin
            timeouts++;
            $display("Timeout waiting for the pipeline to drain");
        end
    endtask

    task automatic wait_retired(input int target, input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(posedge clk);
            n++;
            ok = (retired_cnt >= target);
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout waiting for %0d retires", target);
        end
    endtask

    initial begin
        bit ok;
        int base;
        void'($urandom(26));
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        retire_credit = 1'b0;
        owed          = 0;
        credit_mode   = 0;
        lat_exact     = 1'b0;
        accepted_cnt  = 0;
        retired_cnt   = 0;
        pulse_cnt     = 0;
        errors        = 0;
        timeouts      = 0;
        exp_seq       = '0;
        for (int i = 0; i < `CORE_REG_CNT; i++)
            model_regs[i] = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Random instructions, random credit return
        for (int i = 0; i < 200; i++)
            tx_q.push_back(random_instr());
        wait_drained(20000, ok);

        // Directed dependent chain, then random, credits back at once
        if (ok) begin
            credit_mode = 1;
            lat_exact   = 1'b1;
            tx_q.push_back(enc_i(4'd6, 3'd1, 3'd0, 6'h3b));  // r1 = -5
            tx_q.push_back(enc_r(4'd0, 3'd2, 3'd1, 3'd1));
            tx_q.push_back(enc_r(4'd1, 3'd3, 3'd2, 3'd1));
            tx_q.push_back(enc_r(4'd5, 3'd4, 3'd3, 3'd2));
            tx_q.push_back(enc_i(4'd7, 3'd0, 3'd4, 6'h15));  // Writes r0
            tx_q.push_back(enc_r(4'd4, 3'd5, 3'd0, 3'd4));
            for (int i = 0; i < 40; i++)
                tx_q.push_back(random_instr());
            wait_drained(5000, ok);
        end

        // Withheld credits
        if (ok) begin
            lat_exact   = 1'b0;
            credit_mode = 2;
            base        = retired_cnt;
            for (int i = 0; i < 12; i++)
                tx_q.push_back(random_instr());
            wait_retired(base + `CORE_RETIRE_CREDITS, 500, ok);
            repeat (30) @(posedge clk);
            if (retired_cnt - base > `CORE_RETIRE_CREDITS) begin
                errors++;
                $display("FAILED @%0t: %0d valids while credits withheld",
                         $time, retired_cnt - base);
            end
            credit_mode = 1;
            if (ok)
                wait_drained(5000, ok);
        end

        if (accepted_cnt != retired_cnt || pulse_cnt != accepted_cnt) begin
            errors++;
            $display("FAILED @%0t: accepted %0d retired %0d credit pulses %0d",
                     $time, accepted_cnt, retired_cnt, pulse_cnt);
        end

        $display("Checks done: %0d errors, %0d timeouts, %0d retired",
                 errors, timeouts, retired_cnt);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/core_pkg.sv
decode/instr_decode.sv
execute/alu_execute.sv
src/retire_result.sv
src/pipe_trace.sv
src/core_top.sv
tb/core_assert.sv
tb/core_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := core_tb
FILELIST := verilog.f
LOG      := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) common/core_consts.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
